//--- Makefile
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_mul_top with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f filelist.f \
		--top-module tb_mul_top -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/Vtb_mul_top | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) && echo "run passed" || \
		{ echo "run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/mul_cfg_pkg.sv
`default_nettype none

package mul_cfg_pkg;

    // width of each request operand.
    localparam int OPERAND_WIDTH = 16;

    // full product without truncation.
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    // enough bits to count one step per operand bit.
    localparam int COUNT_WIDTH = $clog2(OPERAND_WIDTH);

    // counter value seen during the final shift-add.
    localparam logic [COUNT_WIDTH-1:0] LAST_STEP = COUNT_WIDTH'(OPERAND_WIDTH - 1);

endpackage : mul_cfg_pkg

`default_nettype wire

//--- design/mul_controller.sv
`default_nettype none

module mul_controller (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     valid_src,
    input  logic                     last_step,
    input  logic                     dst_ready,
    output mul_types_pkg::mul_ctrl_t ctrl,
    output logic                     src_ready,
    output logic                     dst_valid
);

    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        RUN     = 2'b01,
        FINISH  = 2'b10,
        PRESENT = 2'b11
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (valid_src) begin
                    next_state = RUN;  // accept edge.
                end
            end
            RUN: begin
                if (last_step) begin
                    next_state = FINISH;
                end
            end
            FINISH: begin
                next_state = PRESENT;  // always a single cycle.
            end
            PRESENT: begin
                if (dst_ready) begin
                    next_state = IDLE;  // response taken.
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // load follows valid_src in IDLE and all other outputs are Moore.
    always_comb begin
        ctrl      = '0;
        src_ready = 1'b0;
        dst_valid = 1'b0;
        case (state)
            IDLE: begin
                src_ready = 1'b1;
                ctrl.load = valid_src;
            end
            RUN: begin
                ctrl.step = 1'b1;
            end
            FINISH: begin
                ctrl.finish = 1'b1;
            end
            PRESENT: begin
                dst_valid = 1'b1;
            end
            default: begin
                src_ready = 1'b0;
            end
        endcase
    end

    a_ports_exclusive: assert property (
        @(posedge clk) disable iff (!reset)
        !(src_ready && dst_valid)
    ) else $error("src_ready and dst_valid high together");

    a_finish_presents: assert property (
        @(posedge clk) disable iff (!reset)
        ctrl.finish |=> dst_valid
    ) else $error("finish not followed by dst_valid");

    a_rsp_held: assert property (
        @(posedge clk) disable iff (!reset)
        dst_valid && !dst_ready |=> dst_valid
    ) else $error("dst_valid dropped before the sink took the response");

endmodule : mul_controller

`default_nettype wire

//--- design/mul_datapath.sv
`default_nettype none

module mul_datapath (
    input  logic                     clk,
    input  logic                     reset,
    input  mul_types_pkg::mul_req_t  req,
    input  mul_types_pkg::mul_ctrl_t ctrl,
    output logic                     last_step,
    output mul_types_pkg::mul_rsp_t  rsp
);

    import mul_cfg_pkg::*;

    logic [OPERAND_WIDTH-1:0] a_mag;
    logic [OPERAND_WIDTH-1:0] b_mag;
    logic                     neg_in;

    logic [PRODUCT_WIDTH-1:0] mcand;   // multiplicand shifting left.
    logic [OPERAND_WIDTH-1:0] mplier;  // multiplier shifting right.
    logic [PRODUCT_WIDTH-1:0] acc;
    logic                     neg;
    logic [COUNT_WIDTH-1:0]   count;

    // operand magnitudes and product sign of the incoming request.
    always_comb begin
        a_mag  = req.a;
        b_mag  = req.b;
        neg_in = 1'b0;
        if (req.is_signed) begin
            if (req.a[OPERAND_WIDTH-1]) begin
                a_mag = -req.a;  // 16'h8000 stays 32768 unsigned.
            end
            if (req.b[OPERAND_WIDTH-1]) begin
                b_mag = -req.b;
            end
            neg_in = req.a[OPERAND_WIDTH-1] ^ req.b[OPERAND_WIDTH-1];
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            mcand  <= PRODUCT_WIDTH'(a_mag);
            mplier <= b_mag;
            acc    <= '0;
            neg    <= neg_in;
        end else if (ctrl.step) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            count <= '0;
        end else if (ctrl.load) begin
            count <= '0;
        end else if (ctrl.step) begin
            count <= count + 1'b1;  // wraps to zero after the last step.
        end
    end

    assign last_step = ctrl.step && (count == LAST_STEP);

    // result register held until the next finish.
    always_ff @(posedge clk) begin
        if (ctrl.finish) begin
            if (neg) begin
                rsp.product <= -acc;
            end else begin
                rsp.product <= acc;
            end
        end
    end

    // the FSM must stop stepping once the counter has reached its end.
    a_no_extra_step: assert property (
        @(posedge clk) disable iff (!reset)
        last_step |=> !ctrl.step
    ) else $error("shift-add step issued past the last iteration");

    a_last_then_finish: assert property (
        @(posedge clk) disable iff (!reset)
        last_step |=> ctrl.finish
    ) else $error("finish did not follow the last iteration");

endmodule : mul_datapath

`default_nettype wire

//--- design/mul_top.sv
`default_nettype none

module mul_top (
    input  logic                    clk,
    input  logic                    reset,
    input  mul_types_pkg::mul_req_t req,
    input  logic                    valid_src,
    input  logic                    dst_ready,
    output logic                    src_ready,
    output logic                    dst_valid,
    output mul_types_pkg::mul_rsp_t rsp
);

    import mul_types_pkg::*;

    mul_ctrl_t ctrl;
    logic      last_step;  // datapath counter at its end.

    mul_controller u_controller (
        .clk       (clk),
        .reset     (reset),
        .valid_src (valid_src),
        .last_step (last_step),
        .dst_ready (dst_ready),
        .ctrl      (ctrl),
        .src_ready (src_ready),
        .dst_valid (dst_valid)
    );

    mul_datapath u_datapath (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .ctrl      (ctrl),
        .last_step (last_step),
        .rsp       (rsp)
    );

endmodule : mul_top

`default_nettype wire

//--- design/mul_types_pkg.sv
`default_nettype none

package mul_types_pkg;

    import mul_cfg_pkg::*;

    // 33-bit request word.
    typedef struct packed {
        logic [OPERAND_WIDTH-1:0] a;
        logic [OPERAND_WIDTH-1:0] b;
        logic                     is_signed;  // two's complement operands.
    } mul_req_t;

    // response word.
    typedef struct packed {
        logic [PRODUCT_WIDTH-1:0] product;
    } mul_rsp_t;

    // strobes from the FSM to the datapath.
    typedef struct packed {
        logic load;    // accept edge.
        logic step;    // one shift-add.
        logic finish;  // sign fix and result write.
    } mul_ctrl_t;

endpackage : mul_types_pkg

`default_nettype wire

//--- filelist.f
design/mul_cfg_pkg.sv
design/mul_types_pkg.sv
design/mul_controller.sv
design/mul_datapath.sv
design/mul_top.sv
test/tb_mul_top.sv

//--- test/tb_mul_top.sv
`default_nettype none

module tb_mul_top;

    timeunit 1ns;
    timeprecision 100ps;

    import mul_cfg_pkg::*;
    import mul_types_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int N_CORNER    = 7;
    localparam int N_RANDOM    = 40;
    localparam int N_TRANS     = N_CORNER + N_RANDOM;
    localparam int TXN_CYCLES  = 19 + 6 + 3;  // latency, sink stall, source gap.
    localparam int WATCHDOG_NS = N_TRANS * TXN_CYCLES * CLK_PERIOD + 200;

    typedef struct packed {
        logic [PRODUCT_WIDTH-1:0] product;
        logic                     is_signed;
    } expect_t;

    logic     clk = 1'b0;
    logic     reset;
    mul_req_t req;
    logic     valid_src;
    logic     dst_ready;
    logic     src_ready;
    logic     dst_valid;
    mul_rsp_t rsp;

    logic        accept;
    logic        transfer;
    logic        busy;
    int          lat;
    int          done_count;
    int          mismatch_errors;
    int          protocol_errors;
    int unsigned seed_init;
    expect_t     sb[$];  // scoreboard of accepted requests.
    expect_t     entry;
    expect_t     exp_head;

    mul_top DUT (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .valid_src (valid_src),
        .dst_ready (dst_ready),
        .src_ready (src_ready),
        .dst_valid (dst_valid),
        .rsp       (rsp)
    );

    always #2 clk = ~clk;

    assign accept   = valid_src && src_ready;
    assign transfer = dst_valid && dst_ready;

    // expected product straight from the operand values.
    function automatic logic [PRODUCT_WIDTH-1:0] model_product(input mul_req_t r);
        logic signed [PRODUCT_WIDTH-1:0] sext_a;
        logic signed [PRODUCT_WIDTH-1:0] sext_b;
        logic [PRODUCT_WIDTH-1:0]        zext_a;
        logic [PRODUCT_WIDTH-1:0]        zext_b;
        sext_a = {{OPERAND_WIDTH{r.a[OPERAND_WIDTH-1]}}, r.a};
        sext_b = {{OPERAND_WIDTH{r.b[OPERAND_WIDTH-1]}}, r.b};
        zext_a = {{OPERAND_WIDTH{1'b0}}, r.a};
        zext_b = {{OPERAND_WIDTH{1'b0}}, r.b};
        if (r.is_signed) begin
            return sext_a * sext_b;
        end
        return zext_a * zext_b;
    endfunction

    always @(posedge clk or negedge reset) begin
        if (!reset) begin
            busy       <= 1'b0;
            lat        <= 0;
            done_count <= 0;
        end else begin
            if (accept) begin
                entry.product   = model_product(req);
                entry.is_signed = req.is_signed;
                sb.push_back(entry);
                busy <= 1'b1;
                lat  <= 1;  // edge count since acceptance.
            end else if (busy) begin
                lat <= lat + 1;
            end
            if (transfer) begin
                if (sb.size() > 0) begin
                    void'(sb.pop_front());
                end
                busy       <= 1'b0;
                done_count <= done_count + 1;
            end
            if (sb.size() > 0) begin
                exp_head <= sb[0];
            end
        end
    end

    a_reset_state: assert property (
        @(posedge clk) !reset || $rose(reset) |-> src_ready && !dst_valid
    ) else begin
        protocol_errors++;
        $display("reset state wrong: src_ready=%b dst_valid=%b",
                 $sampled(src_ready), $sampled(dst_valid));
    end

    a_unsigned: assert property (
        @(posedge clk) disable iff (!reset)
        transfer && !exp_head.is_signed |-> rsp.product == exp_head.product
    ) else begin
        mismatch_errors++;
        $display("Mismatch unsigned_product: expected %h, actual %h",
                 $sampled(exp_head.product), $sampled(rsp.product));
    end

    a_signed: assert property (
        @(posedge clk) disable iff (!reset)
        transfer && exp_head.is_signed |-> rsp.product == exp_head.product
    ) else begin
        mismatch_errors++;
        $display("Mismatch signed_product: expected %h, actual %h",
                 $sampled(exp_head.product), $sampled(rsp.product));
    end

    a_latency: assert property (
        @(posedge clk) disable iff (!reset)
        $rose(dst_valid) |-> lat == 18
    ) else begin
        mismatch_errors++;
        $display("Mismatch latency: expected 18, actual %0d", $sampled(lat));
    end

    a_src_blocked: assert property (
        @(posedge clk) disable iff (!reset)
        busy |-> !src_ready
    ) else begin
        protocol_errors++;
        $display("request port ready while a multiplication was still pending");
    end

    a_backpressure: assert property (
        @(posedge clk) disable iff (!reset)
        dst_valid && !dst_ready |=> dst_valid && $stable(rsp.product)
    ) else begin
        protocol_errors++;
        $display("response dropped or changed while the sink was stalling");
    end

    a_orphan_rsp: assert property (
        @(posedge clk) disable iff (!reset)
        transfer |-> busy
    ) else begin
        protocol_errors++;
        $display("response transferred with no request outstanding");
    end

    task automatic send_request(input logic [OPERAND_WIDTH-1:0] a,
                                input logic [OPERAND_WIDTH-1:0] b,
                                input logic                     is_signed);
        int gap;
        gap = $urandom_range(0, 3);
        repeat (gap) @(negedge clk);
        req.a         = a;
        req.b         = b;
        req.is_signed = is_signed;
        valid_src     = 1'b1;
        while (!src_ready) @(negedge clk);
        @(negedge clk);  // accepted on the edge just passed.
        valid_src = 1'b0;
        req       = mul_req_t'({$urandom, 1'($urandom)});  // junk while busy.
    endtask

    // sink stalls 0 to 5 cycles per response.
    initial begin
        int stall;
        dst_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (dst_valid) begin
                stall = $urandom_range(0, 5);
                repeat (stall) @(negedge clk);
                dst_ready = 1'b1;
                @(negedge clk);
                dst_ready = 1'b0;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns with %0d of %0d responses", WATCHDOG_NS,
                 done_count, N_TRANS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        seed_init       = $urandom(3686);
        mismatch_errors = 0;
        protocol_errors = 0;
        reset           = 1'b0;
        valid_src       = 1'b0;
        req             = '0;
        repeat (2) @(negedge clk);
        reset = 1'b1;
        send_request(16'h0000, 16'h1234, 1'b0);
        send_request(16'h0001, 16'hbeef, 1'b1);
        send_request(16'hffff, 16'hffff, 1'b0);
        send_request(16'hffff, 16'hffff, 1'b1);
        send_request(16'h8000, 16'h8000, 1'b1);  // largest positive product.
        send_request(16'h8000, 16'h0001, 1'b1);
        send_request(16'h7fff, 16'h8000, 1'b1);
        for (int i = 0; i < N_RANDOM; i++) begin
            send_request(16'($urandom), 16'($urandom), 1'($urandom));
        end
        wait (done_count == N_TRANS);
        repeat (2) @(negedge clk);
        $display("errors: mismatch %0d, protocol %0d", mismatch_errors, protocol_errors);
        if (mismatch_errors == 0 && protocol_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : tb_mul_top

`default_nettype wire
